// File: ProcessorSC.f
hdl/Types.sv
hdl/ProgramCounter.sv
hdl/InstDecoder.sv
hdl/DatapathController.sv
hdl/GPRegisters.sv
hdl/ALU.sv
hdl/ProcessorSC.sv
tests/ProcessorSC_sva.sv
tests/ProcessorSC_tb.sv

// File: hdl/ALU.sv
`timescale 1ns/1ps

module ALU (
    input  Types::DpControl i_control,
    input  Types::Data      i_dataRS1,
    input  Types::Data      i_dataRS2,
    input  Types::Data      i_imm,
    input  Types::InstAddr  i_pc,
    output Types::Data      o_result);  // Also the data address

    import Types::*;

    Data operandA;
    Data operandB;

    // Operand selection
    always_comb begin
        case (i_control.operandASel)
            OpASelPC:   operandA = Data'(i_pc);
            OpASelZero: operandA = '0;  // LUI
            default:    operandA = i_dataRS1;
        endcase
        operandB = (i_control.operandBSel == OpBSelImm) ? i_imm : i_dataRS2;
    end

    always_comb begin
        case (i_control.aluOp)
            AluSub:   o_result = operandA - operandB;
            AluAnd:   o_result = operandA & operandB;
            AluOr:    o_result = operandA | operandB;
            AluXor:   o_result = operandA ^ operandB;
            AluSlt:   o_result = Data'($signed(operandA) < $signed(operandB));
            AluSltu:  o_result = Data'(operandA < operandB);
            AluPassB: o_result = operandB;
            default:  o_result = operandA + operandB;  // ADD, addresses
        endcase
    end

endmodule

// File: hdl/DatapathController.sv
`timescale 1ns/1ps

module DatapathController (
    input  logic            i_clock,
    input  logic            i_arstN,
    input  Types::Inst      i_inst,
    input  Types::Data      i_dataRS1,  // For branch compare
    input  Types::Data      i_dataRS2,
    output Types::DpControl o_control);

    import Types::*;

    Opcode      opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isEqual;
    logic       isLessSigned;
    logic       isLessUnsigned;
    logic       branchTaken;
    logic       running;  // Reset released
    DpControl   ctrl;     // Ungated decode

    assign opcode = Opcode'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    // ----------------------------------------
    // Branch resolution
    // ----------------------------------------

    assign isEqual        = i_dataRS1 == i_dataRS2;
    assign isLessSigned   = $signed(i_dataRS1) < $signed(i_dataRS2);
    assign isLessUnsigned = i_dataRS1 < i_dataRS2;

    always_comb begin
        case (funct3)
            3'b000:  branchTaken = isEqual;          // BEQ
            3'b001:  branchTaken = !isEqual;         // BNE
            3'b100:  branchTaken = isLessSigned;     // BLT
            3'b101:  branchTaken = !isLessSigned;    // BGE
            3'b110:  branchTaken = isLessUnsigned;   // BLTU
            3'b111:  branchTaken = !isLessUnsigned;  // BGEU
            default: branchTaken = 1'b0;
        endcase
    end

    // Set at the falling edge so the first fetched instruction runs in full
    always_ff @(negedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // ----------------------------------------
    // Opcode decode
    // ----------------------------------------

    always_comb begin
        ctrl = '{aluOp: AluAdd, operandASel: OpASelRS1, operandBSel: OpBSelImm,
                 regWrDataSel: RegWrSelAlu, pcNextSel: PcNextPlus4,
                 regWrEnable: 1'b0, memWrEnable: 1'b0, memRdEnable: 1'b0};  // No-op
        case (opcode)
            OpcodeLui: begin
                ctrl.aluOp       = AluPassB;
                ctrl.operandASel = OpASelZero;
                ctrl.regWrEnable = 1'b1;
            end
            OpcodeOpImm: begin
                ctrl.regWrEnable = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = AluAdd;
                    3'b010:  ctrl.aluOp = AluSlt;
                    3'b100:  ctrl.aluOp = AluXor;
                    3'b110:  ctrl.aluOp = AluOr;
                    3'b111:  ctrl.aluOp = AluAnd;
                    default: ctrl.regWrEnable = 1'b0;  // Shifts, SLTIU
                endcase
            end
            OpcodeOp: begin
                ctrl.operandBSel = OpBSelRS2;
                ctrl.regWrEnable = funct7 == 7'b0000000;
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            ctrl.aluOp       = AluSub;
                            ctrl.regWrEnable = 1'b1;
                        end else begin
                            ctrl.aluOp = AluAdd;
                        end
                    end
                    3'b010:  ctrl.aluOp = AluSlt;
                    3'b011:  ctrl.aluOp = AluSltu;
                    3'b100:  ctrl.aluOp = AluXor;
                    3'b110:  ctrl.aluOp = AluOr;
                    3'b111:  ctrl.aluOp = AluAnd;
                    default: ctrl.regWrEnable = 1'b0;
                endcase
            end
            OpcodeLoad: begin
                if (funct3 == 3'b010) begin  // LW only
                    ctrl.regWrDataSel = RegWrSelMem;
                    ctrl.regWrEnable  = 1'b1;
                    ctrl.memRdEnable  = 1'b1;
                end
            end
            OpcodeStore: begin
                ctrl.memWrEnable = funct3 == 3'b010;  // SW only
            end
            OpcodeBranch: begin
                ctrl.aluOp       = AluSub;
                ctrl.operandBSel = OpBSelRS2;
                if (branchTaken) begin
                    ctrl.pcNextSel = PcNextOffset;
                end
            end
            OpcodeJal: begin
                ctrl.operandASel  = OpASelPC;
                ctrl.regWrDataSel = RegWrSelPcPlus4;  // Link
                ctrl.regWrEnable  = 1'b1;
                ctrl.pcNextSel    = PcNextOffset;
            end
            OpcodeJalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.regWrDataSel = RegWrSelPcPlus4;
                    ctrl.regWrEnable  = 1'b1;
                    ctrl.pcNextSel    = PcNextRS1Offset;
                end
            end
            default: ;
        endcase
    end

    // Enables held off until reset has been released
    always_comb begin
        o_control             = ctrl;
        o_control.regWrEnable = ctrl.regWrEnable & running;
        o_control.memWrEnable = ctrl.memWrEnable & running;
        o_control.memRdEnable = ctrl.memRdEnable & running;
    end

endmodule

// File: hdl/GPRegisters.sv
`timescale 1ns/1ps

module GPRegisters (
    input  logic               i_clock,
    input  logic               i_arstN,
    input  Types::GPRAddr      i_rdAddrA,    // rs1
    input  Types::GPRAddr      i_rdAddrB,    // rs2
    input  Types::GPRAddr      i_wrAddr,     // rd
    input  logic               i_wr,
    input  Types::RegWrDataSel i_wrDataSel,  // Write data source
    input  Types::Data         i_aluResult,
    input  Types::Data         i_memRdData,
    input  Types::Data         i_pcPlus4,    // Link address
    output Types::Data         o_rdDataA,
    output Types::Data         o_rdDataB);

    import Types::*;

    Data regs [1:31];  // x0 not stored
    Data wrData;

    // Write side selection
    always_comb begin
        case (i_wrDataSel)
            RegWrSelMem:     wrData = i_memRdData;
            RegWrSelPcPlus4: wrData = i_pcPlus4;
            default:         wrData = i_aluResult;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr && i_wrAddr != '0) begin  // Writes to x0 dropped
            regs[i_wrAddr] <= wrData;
        end
    end

    // Combinational reads, x0 is hardwired zero
    assign o_rdDataA = (i_rdAddrA == '0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 : regs[i_rdAddrB];

endmodule

// File: hdl/InstDecoder.sv
`timescale 1ns/1ps

module InstDecoder (
    input  Types::Inst    i_inst,
    output Types::GPRAddr o_instRS1,
    output Types::GPRAddr o_instRS2,
    output Types::GPRAddr o_instRD,
    output Types::Data    o_instIMM);  // Sign-extended immediate

    import Types::*;

    Opcode opcode;
    logic  sign;  // Immediate sign bit, always inst[31]

    assign opcode = Opcode'(i_inst[6:0]);
    assign sign   = i_inst[31];

    // Register fields sit at fixed positions in every format
    assign o_instRS1 = i_inst[19:15];
    assign o_instRS2 = i_inst[24:20];
    assign o_instRD  = i_inst[11:7];

    // ----------------------------------------
    // Immediate assembly per format
    // ----------------------------------------

    always_comb begin
        case (opcode)
            OpcodeLoad, OpcodeOpImm, OpcodeJalr: begin   // I-type
                o_instIMM = {{20{sign}}, i_inst[31:20]};
            end
            OpcodeStore: begin                           // S-type
                o_instIMM = {{20{sign}}, i_inst[31:25], i_inst[11:7]};
            end
            OpcodeBranch: begin                          // B-type
                o_instIMM = {{19{sign}}, sign, i_inst[7], i_inst[30:25],
                             i_inst[11:8], 1'b0};
            end
            OpcodeLui: begin                             // U-type
                o_instIMM = {i_inst[31:12], 12'b0};
            end
            OpcodeJal: begin                             // J-type
                o_instIMM = {{11{sign}}, sign, i_inst[19:12], i_inst[20],
                             i_inst[30:21], 1'b0};
            end
            default: o_instIMM = '0;                     // R-type has none
        endcase
    end

endmodule

// File: hdl/ProcessorSC.sv
`timescale 1ns/1ps

module ProcessorSC #(
    parameter Types::InstAddr ResetAddr = '0   // Boot address, word aligned
) (
    input  logic             i_clock,
    input  logic             i_arstN,
    input  Types::Inst       i_inst,        // Fetched instruction
    input  Types::Data       i_dataRdData,  // Load data
    output Types::InstAddr   o_instAddr,
    output Types::DataMemReq o_dataReq);

    import Types::*;

    InstAddr  pc;       // Current PC
    InstAddr  pcPlus4;  // Return address for jumps
    GPRAddr   decRS1;
    GPRAddr   decRS2;
    GPRAddr   decRD;
    Data      decIMM;   // Sign-extended immediate
    DpControl control;  // Datapath control bundle
    Data      gprRdDataA;
    Data      gprRdDataB;
    Data      aluResult;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------

    ProgramCounter #(
        .ResetAddr (ResetAddr))
    pcUnit (
        .i_clock     (i_clock),
        .i_arstN     (i_arstN),
        .i_pcNextSel (control.pcNextSel),
        .i_imm       (decIMM),
        .i_dataRS1   (gprRdDataA),
        .o_pc        (pc),
        .o_pcPlus4   (pcPlus4));

    // ----------------------------------------
    // Decode and control
    // ----------------------------------------

    InstDecoder
    dec (
        .i_inst    (i_inst),
        .o_instRS1 (decRS1),
        .o_instRS2 (decRS2),
        .o_instRD  (decRD),
        .o_instIMM (decIMM));

    DatapathController
    dpCtrl (
        .i_clock   (i_clock),
        .i_arstN   (i_arstN),
        .i_inst    (i_inst),
        .i_dataRS1 (gprRdDataA),
        .i_dataRS2 (gprRdDataB),
        .o_control (control));

    // ----------------------------------------
    // Register file and ALU
    // ----------------------------------------

    GPRegisters
    gpr (
        .i_clock     (i_clock),
        .i_arstN     (i_arstN),
        .i_rdAddrA   (decRS1),
        .i_rdAddrB   (decRS2),
        .i_wrAddr    (decRD),
        .i_wr        (control.regWrEnable),
        .i_wrDataSel (control.regWrDataSel),
        .i_aluResult (aluResult),
        .i_memRdData (i_dataRdData),
        .i_pcPlus4   (Data'(pcPlus4)),
        .o_rdDataA   (gprRdDataA),
        .o_rdDataB   (gprRdDataB));

    ALU
    alu (
        .i_control (control),
        .i_dataRS1 (gprRdDataA),
        .i_dataRS2 (gprRdDataB),
        .i_imm     (decIMM),
        .i_pc      (pc),
        .o_result  (aluResult));

    // Memory ports
    always_comb begin
        o_dataReq.addr   = DataAddr'(aluResult);
        o_dataReq.wrData = gprRdDataB;           // SW data from rs2
        o_dataReq.wr     = control.memWrEnable;
        o_dataReq.rd     = control.memRdEnable;
    end

    assign o_instAddr = pc;

endmodule

// File: hdl/ProgramCounter.sv
`timescale 1ns/1ps

module ProgramCounter #(
    parameter Types::InstAddr ResetAddr = '0   // First fetch address
) (
    input  logic            i_clock,
    input  logic            i_arstN,
    input  Types::PcNextSel i_pcNextSel,  // Next PC source
    input  Types::Data      i_imm,        // Branch/jump offset
    input  Types::Data      i_dataRS1,    // Base for JALR
    output Types::InstAddr  o_pc,
    output Types::InstAddr  o_pcPlus4);

    import Types::*;

    InstAddr pc;
    InstAddr pcNext;
    InstAddr pcPlus4;
    InstAddr pcPlusOffset;   // JAL and taken branches
    InstAddr rs1PlusOffset;  // JALR target
    Data     rs1Sum;

    // Candidate addresses
    assign pcPlus4       = pc + InstAddr'(4);
    assign pcPlusOffset  = pc + InstAddr'(i_imm);
    assign rs1Sum        = i_dataRS1 + i_imm;
    assign rs1PlusOffset = InstAddr'({rs1Sum[$bits(Data)-1:1], 1'b0});  // Bit 0 cleared

    always_comb begin
        case (i_pcNextSel)
            PcNextOffset:    pcNext = pcPlusOffset;
            PcNextRS1Offset: pcNext = rs1PlusOffset;
            default:         pcNext = pcPlus4;
        endcase
    end

    // PC register, loads every cycle
    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= ResetAddr;
        end else begin
            pc <= pcNext;
        end
    end

    assign o_pc      = pc;
    assign o_pcPlus4 = pcPlus4;

endmodule

// File: hdl/Types.sv
package Types;

    // ----------------------------------------
    // Value types
    // ----------------------------------------

    typedef logic [31:0] Data;      // Register or memory word
    typedef logic [31:0] InstAddr;  // Instruction byte address
    typedef logic [31:0] DataAddr;  // Data byte address
    typedef logic [31:0] Inst;      // Instruction word
    typedef logic [4:0]  GPRAddr;   // Register index x0..x31

    // ----------------------------------------
    // Control encodings
    // ----------------------------------------

    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSltu, AluPassB
    } AluOp;

    typedef enum logic [1:0] {OpASelRS1, OpASelPC, OpASelZero} OperandASel;
    typedef enum logic {OpBSelRS2, OpBSelImm} OperandBSel;
    typedef enum logic [1:0] {RegWrSelAlu, RegWrSelMem, RegWrSelPcPlus4} RegWrDataSel;
    typedef enum logic [1:0] {PcNextPlus4, PcNextOffset, PcNextRS1Offset} PcNextSel;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OpcodeLoad   = 7'b0000011,
        OpcodeOpImm  = 7'b0010011,
        OpcodeStore  = 7'b0100011,
        OpcodeOp     = 7'b0110011,
        OpcodeLui    = 7'b0110111,
        OpcodeBranch = 7'b1100011,
        OpcodeJalr   = 7'b1100111,
        OpcodeJal    = 7'b1101111
    } Opcode;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------

    typedef struct packed {
        DataAddr addr;    // Byte address, word aligned
        Data     wrData;  // Store data
        logic    wr;      // Write strobe
        logic    rd;      // Read strobe
    } DataMemReq;

    typedef struct packed {
        AluOp        aluOp;
        OperandASel  operandASel;
        OperandBSel  operandBSel;
        RegWrDataSel regWrDataSel;
        PcNextSel    pcNextSel;
        logic        regWrEnable;
        logic        memWrEnable;
        logic        memRdEnable;
    } DpControl;

endpackage

// File: tests/ProcessorSC_sva.sv
`timescale 1ns/1ps

module ProcessorSC_sva (
    input logic             i_clock,
    input logic             i_arstN,
    input Types::InstAddr   i_instAddr,
    input Types::DataMemReq i_dataReq);

    // Fetch stays on a word boundary, reset included
    instAligned: assert property (@(posedge i_clock) i_instAddr[1:0] == 2'b00)
        else $error("Fetch address %h is not word aligned", i_instAddr);

    // Load and store never in the same cycle
    oneRequest: assert property (@(posedge i_clock) !(i_dataReq.wr && i_dataReq.rd))
        else $error("Read and write strobes high together");

    quietInReset: assert property (
        @(posedge i_clock) !i_arstN |-> !i_dataReq.wr && !i_dataReq.rd)
        else $error("Memory strobe high while reset is asserted");

endmodule

bind ProcessorSC ProcessorSC_sva sva (
    .i_clock    (i_clock),
    .i_arstN    (i_arstN),
    .i_instAddr (o_instAddr),
    .i_dataReq  (o_dataReq));

// File: tests/ProcessorSC_tb.sv
`timescale 1ns/1ps

module ProcessorSC_tb;

    import Types::*;

    localparam InstAddr ResetAddr   = 32'h0000_0020;  // Non-zero boot address
    localparam int      EdgeTimeout = 100;            // ns allowed between rising edges
    localparam real     DriveDelay  = 2.0;            // Inputs change after the edge
    localparam real     SampleDelay = 28.0;           // Drive point to check point

    typedef struct packed {
        InstAddr pc;     // Expected fetch address
        Inst     inst;   // Instruction placed at that address
        logic    store;  // SW expected in this cycle
        logic    load;   // LW expected in this cycle
        DataAddr addr;
        Data     data;
    } Step;

    logic      clock = 1'b0;
    logic      arstN;
    Inst       inst;
    Data       dataRdData;
    InstAddr   instAddr;
    DataMemReq dataReq;

    Inst         imem [128];
    Data         dmem [64];
    Data         xm [32] = '{default: '0};  // Register model for expected values
    Step         steps [$];
    InstAddr     pc;                        // Build-time PC
    logic [31:0] lfsr = 32'hc648_66fa;
    int          edgeCount = 0;
    realtime     lastEdge = 0.0;
    logic        timedOut = 1'b0;
    int          checks = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;

    ProcessorSC #(
        .ResetAddr (ResetAddr))
    i_ProcessorSC (
        .i_clock      (clock),
        .i_arstN      (arstN),
        .i_inst       (inst),
        .i_dataRdData (dataRdData),
        .o_instAddr   (instAddr),
        .o_dataReq    (dataReq));

    // ----------------------------------------
    // Clock and memory models
    // ----------------------------------------

    always #20 clock = ~clock;  // 40 ns period

    always @(posedge clock) begin
        edgeCount++;
        lastEdge = $realtime;
    end

    assign inst       = imem[instAddr[8:2]];       // Combinational fetch
    assign dataRdData = dmem[dataReq.addr[7:2]];

    always @(posedge clock) begin
        if (dataReq.wr) begin
            dmem[dataReq.addr[7:2]] <= dataReq.wrData;  // SW lands at the edge
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    function automatic Data sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // ----------------------------------------
    // RV32I encoders
    // ----------------------------------------

    function automatic Inst rType(logic [6:0] f7, GPRAddr rs2, GPRAddr rs1, logic [2:0] f3,
                                  GPRAddr rd);
        return {f7, rs2, rs1, f3, rd, OpcodeOp};
    endfunction

    function automatic Inst iType(logic [11:0] imm, GPRAddr rs1, logic [2:0] f3, GPRAddr rd,
                                  Opcode op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic Inst sType(logic [11:0] imm, GPRAddr rs2, GPRAddr rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcodeStore};
    endfunction

    function automatic Inst bType(logic [12:0] imm, GPRAddr rs2, GPRAddr rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcodeBranch};
    endfunction

    function automatic Inst jType(logic [20:0] imm, GPRAddr rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcodeJal};
    endfunction

    // ----------------------------------------
    // Program and expected table
    // ----------------------------------------

    task automatic addStep(Inst code, logic store, DataAddr addr, Data data,
                           logic load = 1'b0);
        steps.push_back('{pc: pc, inst: code, store: store, load: load, addr: addr,
                          data: data});
        pc += 4;
    endtask

    task automatic setReg(GPRAddr rd, Data value);
        if (rd != '0) begin
            xm[rd] = value;  // x0 ignores writes
        end
    endtask

    task automatic lui(GPRAddr rd, logic [19:0] imm);
        addStep({imm, rd, OpcodeLui}, 1'b0, '0, '0);
        setReg(rd, {imm, 12'b0});
    endtask

    task automatic opImm(logic [2:0] f3, GPRAddr rd, GPRAddr rs1, logic [11:0] imm,
                         Data result);
        addStep(iType(imm, rs1, f3, rd, OpcodeOpImm), 1'b0, '0, '0);
        setReg(rd, result);
    endtask

    task automatic opReg(logic [6:0] f7, logic [2:0] f3, GPRAddr rd, GPRAddr rs1, GPRAddr rs2,
                         Data result);
        addStep(rType(f7, rs2, rs1, f3, rd), 1'b0, '0, '0);
        setReg(rd, result);
    endtask

    task automatic storeWord(GPRAddr rs2, GPRAddr rs1, logic [11:0] imm);
        addStep(sType(imm, rs2, rs1), 1'b1, xm[rs1] + sext12(imm), xm[rs2]);
    endtask

    task automatic loadWord(GPRAddr rd, GPRAddr rs1, logic [11:0] imm);
        DataAddr addr;
        addr = xm[rs1] + sext12(imm);
        addStep(iType(imm, rs1, 3'b010, rd, OpcodeLoad), 1'b0, addr, '0, 1'b1);
        setReg(rd, dmem[addr[7:2]]);  // Preloaded word
    endtask

    task automatic branch(logic [2:0] f3, GPRAddr rs1, GPRAddr rs2, logic taken);
        InstAddr target;
        target = pc + 8;  // Taken skips one slot
        addStep(bType(13'd8, rs2, rs1, f3), 1'b0, '0, '0);
        if (taken) begin
            pc = target;
        end
    endtask

    task automatic jal(GPRAddr rd, logic [20:0] offset);
        InstAddr target;
        InstAddr link;
        target = pc + {{11{offset[20]}}, offset};
        link   = pc + 4;
        addStep(jType(offset, rd), 1'b0, '0, '0);
        setReg(rd, link);
        pc = target;
    endtask

    task automatic jalr(GPRAddr rd, GPRAddr rs1, logic [11:0] imm);
        InstAddr target;
        InstAddr link;
        target = (xm[rs1] + sext12(imm)) & ~32'h1;  // Low bit cleared
        link   = pc + 4;
        addStep(iType(imm, rs1, 3'b000, rd, OpcodeJalr), 1'b0, '0, '0);
        setReg(rd, link);
        pc = target;
    endtask

    task automatic buildProgram();
        logic [19:0] upper;
        logic [11:0] lower;
        pc    = ResetAddr;
        storeWord(0, 0, 12'h0FC);  // Store sits at the boot address during reset
        upper = 20'(randomBits(20));
        lui(1, upper);
        lower = 12'(randomBits(12));
        opImm(3'b000, 1, 1, lower, xm[1] + sext12(lower));
        upper = 20'(randomBits(20));
        lui(2, upper);
        lower = 12'(randomBits(12));
        opImm(3'b000, 2, 2, lower, xm[2] + sext12(lower));
        opImm(3'b000, 3, 0, 12'h080, xm[0] + sext12(12'h080));  // Store base
        opReg(7'h00, 3'b000, 4, 1, 2, xm[1] + xm[2]);
        storeWord(4, 3, 12'd0);
        opReg(7'h20, 3'b000, 4, 1, 2, xm[1] - xm[2]);
        storeWord(4, 3, 12'd4);
        opReg(7'h00, 3'b111, 4, 1, 2, xm[1] & xm[2]);
        storeWord(4, 3, 12'd8);
        opReg(7'h00, 3'b110, 4, 1, 2, xm[1] | xm[2]);
        storeWord(4, 3, 12'd12);
        opReg(7'h00, 3'b100, 4, 1, 2, xm[1] ^ xm[2]);
        storeWord(4, 3, 12'd16);
        opReg(7'h00, 3'b010, 4, 1, 2, Data'($signed(xm[1]) < $signed(xm[2])));
        storeWord(4, 3, 12'd20);
        opReg(7'h00, 3'b011, 4, 1, 2, Data'(xm[1] < xm[2]));
        storeWord(4, 3, 12'd24);
        opImm(3'b111, 4, 1, 12'h7F0, xm[1] & sext12(12'h7F0));
        storeWord(4, 3, 12'd28);
        opImm(3'b110, 4, 1, 12'hFF0, xm[1] | sext12(12'hFF0));
        storeWord(4, 3, 12'd32);
        opImm(3'b100, 4, 2, 12'h555, xm[2] ^ sext12(12'h555));
        storeWord(4, 3, 12'd36);
        opImm(3'b010, 4, 1, 12'hFFF, Data'($signed(xm[1]) < $signed(sext12(12'hFFF))));
        storeWord(4, 3, 12'd40);
        opImm(3'b000, 0, 1, 12'd5, xm[1] + 32'd5);  // Write to x0
        storeWord(0, 3, 12'd44);
        loadWord(12, 0, 12'd4);
        storeWord(12, 3, 12'd48);
        lui(13, 20'h80000);                                       // Most negative
        opImm(3'b000, 14, 13, 12'hFFF, xm[13] + sext12(12'hFFF)); // Most positive
        opImm(3'b000, 15, 0, 12'hFFF, sext12(12'hFFF));           // All ones
        branch(3'b000, 1, 1, xm[1] == xm[1]);
        branch(3'b000, 1, 2, xm[1] == xm[2]);
        branch(3'b001, 13, 14, xm[13] != xm[14]);
        branch(3'b001, 15, 15, xm[15] != xm[15]);
        branch(3'b100, 13, 14, $signed(xm[13]) < $signed(xm[14]));
        branch(3'b100, 14, 13, $signed(xm[14]) < $signed(xm[13]));
        branch(3'b101, 15, 13, $signed(xm[15]) >= $signed(xm[13]));
        branch(3'b101, 13, 15, $signed(xm[13]) >= $signed(xm[15]));
        branch(3'b110, 14, 13, xm[14] < xm[13]);
        branch(3'b110, 15, 14, xm[15] < xm[14]);
        branch(3'b111, 15, 13, xm[15] >= xm[13]);
        branch(3'b111, 0, 15, xm[0] >= xm[15]);
        jal(10, 21'd12);
        storeWord(10, 3, 12'd52);
        jalr(11, 10, 12'(pc + 9 - xm[10]));  // Odd sum, lands two slots on
        storeWord(11, 3, 12'd56);
    endtask

    // ----------------------------------------
    // Checks and waits
    // ----------------------------------------

    task automatic checkInstAddr(string name, InstAddr actual, InstAddr expected);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkDataAddr(string name, DataAddr actual, DataAddr expected);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkData(string name, Data actual, Data expected);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkStep(Step s);
        checkInstAddr("o_instAddr", instAddr, s.pc);
        if (dataReq.wr !== s.store) begin
            otherErrors++;
            $display("At %0t the instruction at %h %s store", $time, s.pc,
                     s.store ? "did not make its" : "made an unexpected");
        end else if (s.store) begin
            checkDataAddr("o_dataReq.addr", dataReq.addr, s.addr);
            checkData("o_dataReq.wrData", dataReq.wrData, s.data);
        end
        if (dataReq.rd !== s.load) begin
            otherErrors++;
            $display("At %0t the instruction at %h %s load", $time, s.pc,
                     s.load ? "did not make its" : "made an unexpected");
        end else if (s.load) begin
            checkDataAddr("o_dataReq.addr", dataReq.addr, s.addr);
        end
    endtask

    // Polls for the next rising edge, then moves to the drive point
    task automatic waitEdge();
        int startCount;
        int polls;
        startCount = edgeCount;
        polls      = 0;
        while (edgeCount == startCount && polls < EdgeTimeout) begin
            #1;
            polls++;
        end
        if (edgeCount == startCount) begin
            otherErrors++;
            timedOut = 1'b1;
            $display("Timeout, no rising clock edge within %0d ns", EdgeTimeout);
        end else begin
            #(lastEdge + DriveDelay - $realtime);
        end
    endtask

    initial begin
        arstN = 1'b0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {~16'(i * 4), 16'(i * 4)};  // Pattern from byte address
        end
        for (int i = 0; i < 128; i++) begin
            imem[i] = {25'(i * 4), 7'b0000000};   // Opcode 0 decodes as no-op
        end
        buildProgram();
        foreach (steps[k]) begin
            imem[steps[k].pc[8:2]] = steps[k].inst;
        end

        // Reset cycles, memory must stay quiet
        for (int c = 0; c < 10 && !timedOut; c++) begin
            waitEdge();
            #(SampleDelay);
            if (dataReq.wr !== 1'b0 || dataReq.rd !== 1'b0) begin
                otherErrors++;
                $display("Memory request seen during reset at %0t", $time);
            end
        end
        waitEdge();
        arstN = 1'b1;

        // One table row per executed instruction
        for (int k = 0; k < steps.size() && !timedOut; k++) begin
            #(SampleDelay);
            checkStep(steps[k]);
            waitEdge();
        end

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
